/* compile.f */
design/cpu_mem_pkg.sv
design/fetch_port.sv
design/ls_port.sv
design/axi_arbiter.sv
design/cpu_mem_bridge.sv
tests/axi_mem_model.sv
tests/tb_cpu_mem_bridge.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_cpu_mem_bridge
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tests/tb_cpu_mem_bridge.sv */
`timescale 1ns/1ns

module tb_cpu_mem_bridge
	import cpu_mem_pkg::*;
;

	localparam int N_TESTS      = 5;
	localparam int WORST_CYCLES = 600;   // per test with random stalls

	logic aclk = 1'b0;
	logic i_rst_n;
	logic i_if_req_valid, o_if_req_ready, o_if_rsp_valid, o_if_rsp_err, i_if_rsp_ready;
	logic i_ls_req_valid, o_ls_req_ready, i_ls_write, o_ls_rsp_valid, o_ls_rsp_err;
	logic i_ls_rsp_ready;
	addr_t i_if_addr, i_ls_addr;
	size_t i_ls_size;
	data_t o_if_rsp_data, i_ls_wdata, o_ls_rsp_data;
	addr_t o_araddr, o_awaddr;
	logic [2:0] o_arsize, o_awsize;
	logic o_arvalid, i_arready, i_rvalid, o_rready, o_awvalid, i_awready;
	logic o_wvalid, i_wready, i_bvalid, o_bready;
	data_t i_rdata, o_wdata;
	strb_t o_wstrb;
	axi_resp_t i_rresp, i_bresp;

	integer seed = 32'h42d1;
	int     err_count = 0;
	int     tests_run = 0;
	int     errs_before;
	data_t  shadow [256];
	data_t  exp_if_data, exp_ls_data;
	logic   exp_if_err, exp_ls_err;
	logic [2:0] exp_arsize = 3'd2;   // log2 of the bytes read
	logic   no_bus = 1'b0;   // misaligned tests expect a quiet AXI port

	always #4 aclk = ~aclk;

	cpu_mem_bridge #(.LS_FIRST(1'b1)) i_cpu_mem_bridge (.*);

	axi_mem_model i_axi_mem (
		.aclk(aclk), .i_rst_n(i_rst_n),
		.i_araddr(o_araddr), .i_arvalid(o_arvalid), .o_arready(i_arready),
		.o_rdata(i_rdata), .o_rresp(i_rresp), .o_rvalid(i_rvalid), .i_rready(o_rready),
		.i_awaddr(o_awaddr), .i_awsize(o_awsize), .i_awvalid(o_awvalid),
		.o_awready(i_awready), .i_wdata(o_wdata), .i_wstrb(o_wstrb), .i_wvalid(o_wvalid),
		.o_wready(i_wready), .o_bresp(i_bresp), .o_bvalid(i_bvalid), .i_bready(o_bready)
	);

	function automatic data_t fill_word(input int idx);
		data_t a;
		a = data_t'(idx) << 2;
		return (a * 32'h9e3779b1) ^ 32'h5a5ac3c3;   // spreads every address bit
	endfunction

	function automatic addr_t map_segment(input addr_t va);
		return (va[31:30] == 2'b10) ? {3'b000, va[28:0]} : va;   // kseg0 and kseg1
	endfunction

	function automatic logic rand_bit();
		return 1'(($random(seed) & 1) != 0);
	endfunction

	task automatic fetch(input addr_t va, input bit bp);
		addr_t pa;
		pa = map_segment(va);
		exp_if_err  = (va[1:0] != 2'b00) || (pa[9:8] == 2'b11);
		exp_if_data = shadow[pa[9:2]];
		exp_arsize  = 3'd2;   // fetches are whole words
		@(negedge aclk);
		i_if_req_valid = 1'b1;
		i_if_addr = va;
		while (!o_if_req_ready) @(negedge aclk);
		@(negedge aclk);
		i_if_req_valid = 1'b0;
		forever begin
			i_if_rsp_ready = bp ? rand_bit() : 1'b1;
			if (o_if_rsp_valid && i_if_rsp_ready) break;
			@(negedge aclk);
		end
		@(negedge aclk);
		i_if_rsp_ready = 1'b0;
	endtask

	task automatic load_store(input addr_t va, input logic wr, input size_t sz,
		input data_t wd, input bit bp);
		addr_t pa;
		logic  misal;
		int    lo;
		pa = map_segment(va);
		lo = int'(pa[1:0]);
		misal = (sz == SIZE_HALF) ? va[0] : (sz == SIZE_WORD) ? (va[1:0] != 2'b00) : 1'b0;
		exp_ls_err = misal || (pa[9:8] == 2'b11);
		if (sz == SIZE_BYTE) exp_arsize = 3'd0;
		else if (sz == SIZE_HALF) exp_arsize = 3'd1;
		else exp_arsize = 3'd2;
		if (sz == SIZE_BYTE) exp_ls_data = {24'b0, shadow[pa[9:2]][8*lo +: 8]};
		else if (sz == SIZE_HALF) exp_ls_data = {16'b0, shadow[pa[9:2]][8*lo +: 16]};
		else exp_ls_data = shadow[pa[9:2]];
		if (wr) begin
			exp_ls_data = '0;   // stores answer with zero
			if (!exp_ls_err) begin
				if (sz == SIZE_BYTE) shadow[pa[9:2]][8*lo +: 8] = wd[7:0];
				else if (sz == SIZE_HALF) shadow[pa[9:2]][8*lo +: 16] = wd[15:0];
				else shadow[pa[9:2]] = wd;
			end
		end
		@(negedge aclk);
		i_ls_req_valid = 1'b1;
		i_ls_addr = va;
		i_ls_write = wr;
		i_ls_size = sz;
		i_ls_wdata = wd;
		while (!o_ls_req_ready) @(negedge aclk);
		@(negedge aclk);
		i_ls_req_valid = 1'b0;
		forever begin
			i_ls_rsp_ready = bp ? rand_bit() : 1'b1;
			if (o_ls_rsp_valid && i_ls_rsp_ready) break;
			@(negedge aclk);
		end
		@(negedge aclk);
		i_ls_rsp_ready = 1'b0;
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = err_count + i_axi_mem.fail_count;
		tests_run++;
		$display("test %0d %s: %s", tests_run, name, (errs == errs_before) ? "ok" : "errors");
		errs_before = errs;
	endtask

	a_if_err: assert property (@(posedge aclk) disable iff (!i_rst_n)
		o_if_rsp_valid && i_if_rsp_ready |-> o_if_rsp_err == exp_if_err)
		else begin
			err_count++;
			$display("[ERROR] %0t o_if_rsp_err expected %b got %b", $time, exp_if_err,
				$sampled(o_if_rsp_err));
		end
	a_if_data: assert property (@(posedge aclk) disable iff (!i_rst_n)
		o_if_rsp_valid && i_if_rsp_ready && !exp_if_err |-> o_if_rsp_data == exp_if_data)
		else begin
			err_count++;
			$display("[ERROR] %0t o_if_rsp_data expected %h got %h", $time, exp_if_data,
				$sampled(o_if_rsp_data));
		end
	a_ls_err: assert property (@(posedge aclk) disable iff (!i_rst_n)
		o_ls_rsp_valid && i_ls_rsp_ready |-> o_ls_rsp_err == exp_ls_err)
		else begin
			err_count++;
			$display("[ERROR] %0t o_ls_rsp_err expected %b got %b", $time, exp_ls_err,
				$sampled(o_ls_rsp_err));
		end
	a_ls_data: assert property (@(posedge aclk) disable iff (!i_rst_n)
		o_ls_rsp_valid && i_ls_rsp_ready && !exp_ls_err |-> o_ls_rsp_data == exp_ls_data)
		else begin
			err_count++;
			$display("[ERROR] %0t o_ls_rsp_data expected %h got %h", $time, exp_ls_data,
				$sampled(o_ls_rsp_data));
		end
	a_ar_phys: assert property (@(posedge aclk) disable iff (!i_rst_n)
		o_arvalid && i_arready |-> o_araddr[31:29] == 3'b000)
		else begin
			err_count++;
			$display("[ERROR] %0t o_araddr expected top bits 000 got %h", $time,
				$sampled(o_araddr));
		end
	a_ar_size: assert property (@(posedge aclk) disable iff (!i_rst_n)
		o_arvalid && i_arready |-> o_arsize == exp_arsize)
		else begin
			err_count++;
			$display("[ERROR] %0t o_arsize expected %0d got %0d", $time, exp_arsize,
				$sampled(o_arsize));
		end
	a_quiet_axi: assert property (@(posedge aclk) disable iff (!i_rst_n)
		no_bus |-> !(o_arvalid && i_arready) && !(o_awvalid && i_awready))
		else begin
			err_count++;
			$display("misaligned access reached the AXI port at %0t", $time);
		end

	initial begin
		#(N_TESTS * WORST_CYCLES * 8);
		$display("watchdog expired before the tests finished");
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		i_rst_n = 1'b0;
		i_if_req_valid = 1'b0;
		i_if_addr = '0;
		i_if_rsp_ready = 1'b0;
		i_ls_req_valid = 1'b0;
		i_ls_addr = '0;
		i_ls_write = 1'b0;
		i_ls_size = SIZE_WORD;
		i_ls_wdata = '0;
		errs_before = 0;
		for (int i = 0; i < 256; i++) begin
			i_axi_mem.mem[i] = fill_word(i);
			shadow[i] = fill_word(i);
		end
		repeat (3) @(posedge aclk);
		@(negedge aclk);
		i_rst_n = 1'b1;

		load_store(32'h8000_0040, 1'b1, SIZE_WORD, 32'hdead_beef, 1'b0);
		load_store(32'h8000_0040, 1'b0, SIZE_WORD, '0, 1'b0);
		end_test("word store then load");

		load_store(32'ha000_0081, 1'b1, SIZE_BYTE, 32'h1234_56a7, 1'b0);
		load_store(32'ha000_0082, 1'b1, SIZE_HALF, 32'h0000_c3d2, 1'b0);
		load_store(32'h8000_0080, 1'b0, SIZE_WORD, '0, 1'b0);
		load_store(32'h8000_0081, 1'b0, SIZE_BYTE, '0, 1'b0);
		load_store(32'h8000_0083, 1'b0, SIZE_BYTE, '0, 1'b0);
		end_test("byte and halfword stores");

		fetch(32'h8000_0100, 1'b0);
		fetch(32'ha000_0100, 1'b0);
		end_test("segment mapping");

		no_bus = 1'b1;
		fetch(32'h8000_0102, 1'b0);
		load_store(32'h8000_0105, 1'b0, SIZE_HALF, '0, 1'b0);
		no_bus = 1'b0;
		end_test("misaligned access");

		for (int n = 0; n < 10; n++) begin
			fork
				fetch({22'h200000, 8'(($random(seed) & 127)), 2'b00}, 1'b1);
				load_store({22'h280000, 8'(($random(seed) & 127)), 2'b00}, 1'b0,
					SIZE_WORD, '0, 1'b1);
			join
		end
		fork
			fetch(32'h8000_0380, 1'b1);
			load_store(32'ha000_0310, 1'b0, SIZE_WORD, '0, 1'b1);
		join
		end_test("concurrent traffic");

		$display("%0d tests run, %0d checks failed", tests_run,
			err_count + i_axi_mem.fail_count);
		if (err_count + i_axi_mem.fail_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* tests/axi_mem_model.sv */
`timescale 1ns/1ns

module axi_mem_model
	import cpu_mem_pkg::*;
(
	input  logic       aclk,
	input  logic       i_rst_n,
	input  addr_t      i_araddr,
	input  logic       i_arvalid,
	output logic       o_arready,
	output data_t      o_rdata,
	output axi_resp_t  o_rresp,
	output logic       o_rvalid,
	input  logic       i_rready,
	input  addr_t      i_awaddr,
	input  logic [2:0] i_awsize,
	input  logic       i_awvalid,
	output logic       o_awready,
	input  data_t      i_wdata,
	input  strb_t      i_wstrb,
	input  logic       i_wvalid,
	output logic       o_wready,
	output axi_resp_t  o_bresp,
	output logic       o_bvalid,
	input  logic       i_bready
);

	data_t  mem [256];   // preloaded from the testbench
	integer seed = 32'h42d1;
	int     fail_count = 0;
	logic   rd_pend;
	logic   aw_got;
	logic   w_got;
	addr_t  rd_addr;
	addr_t  wr_addr;
	data_t  wr_data;
	strb_t  wr_strb;

	// 0x300..0x3ff answers SLVERR
	function automatic logic in_err_window(input addr_t a);
		return a[9:8] == 2'b11;
	endfunction

	function automatic strb_t lane_mask(input addr_t a, input logic [2:0] sz);
		strb_t m;
		case (sz)
			3'd0: m = 4'b0001;
			3'd1: m = 4'b0011;
			default: m = 4'b1111;
		endcase
		return m << a[1:0];
	endfunction

	// handshakes seen on the rising edge
	always @(posedge aclk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rd_pend <= 1'b0;
			aw_got  <= 1'b0;
			w_got   <= 1'b0;
		end else begin
			if (i_arvalid && o_arready) begin
				rd_addr <= i_araddr;
				rd_pend <= 1'b1;
			end
			if (o_rvalid && i_rready) rd_pend <= 1'b0;
			if (i_awvalid && o_awready) begin
				wr_addr <= i_awaddr;
				aw_got  <= 1'b1;
			end
			if (i_wvalid && o_wready) begin
				wr_data <= i_wdata;
				wr_strb <= i_wstrb;
				w_got   <= 1'b1;
			end
			if (o_bvalid && i_bready) begin
				aw_got <= 1'b0;
				w_got  <= 1'b0;
			end
		end
	end

	// outputs change on the falling edge with random readies
	always @(negedge aclk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_arready <= 1'b0;
			o_awready <= 1'b0;
			o_wready  <= 1'b0;
			o_rvalid  <= 1'b0;
			o_bvalid  <= 1'b0;
			o_rresp   <= RESP_OKAY;
			o_bresp   <= RESP_OKAY;
			o_rdata   <= '0;
		end else begin
			o_arready <= !rd_pend && (($random(seed) & 3) != 0);
			o_awready <= !aw_got && (($random(seed) & 3) != 0);
			o_wready  <= !w_got && (($random(seed) & 3) != 0);
			if (rd_pend && !o_rvalid && (($random(seed) & 1) != 0)) begin
				o_rvalid <= 1'b1;
				o_rdata  <= mem[rd_addr[9:2]];
				o_rresp  <= in_err_window(rd_addr) ? RESP_SLVERR : RESP_OKAY;
			end else if (!rd_pend) begin
				o_rvalid <= 1'b0;
			end
			if (aw_got && w_got && !o_bvalid && (($random(seed) & 1) != 0)) begin
				for (int b = 0; b < STRB_W; b++) begin
					if (wr_strb[b] && !in_err_window(wr_addr))
						mem[wr_addr[9:2]][8*b +: 8] = wr_data[8*b +: 8];
				end
				o_bvalid <= 1'b1;
				o_bresp  <= in_err_window(wr_addr) ? RESP_SLVERR : RESP_OKAY;
			end else if (!(aw_got && w_got)) begin
				o_bvalid <= 1'b0;
			end
		end
	end

	a_wstrb_lanes: assert property (@(posedge aclk) disable iff (!i_rst_n)
		i_awvalid && o_awready |-> i_wstrb == lane_mask(i_awaddr, i_awsize))
		else begin
			fail_count++;
			$display("[ERROR] %0t i_wstrb expected %h got %h", $time,
				lane_mask($sampled(i_awaddr), $sampled(i_awsize)), $sampled(i_wstrb));
		end
	a_one_txn: assert property (@(posedge aclk) disable iff (!i_rst_n)
		!(rd_pend && (aw_got || w_got)))
		else begin
			fail_count++;
			$display("read and write transactions overlap at the memory at %0t", $time);
		end

endmodule

/* design/cpu_mem_bridge.sv */
`timescale 1ns/1ns

module cpu_mem_bridge
	import cpu_mem_pkg::*;
#(
	parameter bit LS_FIRST = 1'b1
) (
	input  logic       aclk,
	input  logic       i_rst_n,
	// instruction fetch
	input  logic       i_if_req_valid,
	output logic       o_if_req_ready,
	input  addr_t      i_if_addr,
	output logic       o_if_rsp_valid,
	output data_t      o_if_rsp_data,
	output logic       o_if_rsp_err,
	input  logic       i_if_rsp_ready,
	// load/store
	input  logic       i_ls_req_valid,
	output logic       o_ls_req_ready,
	input  addr_t      i_ls_addr,
	input  logic       i_ls_write,
	input  size_t      i_ls_size,
	input  data_t      i_ls_wdata,
	output logic       o_ls_rsp_valid,
	output data_t      o_ls_rsp_data,
	output logic       o_ls_rsp_err,
	input  logic       i_ls_rsp_ready,
	// AXI master
	output addr_t      o_araddr,
	output logic [2:0] o_arsize,
	output logic       o_arvalid,
	input  logic       i_arready,
	input  data_t      i_rdata,
	input  axi_resp_t  i_rresp,
	input  logic       i_rvalid,
	output logic       o_rready,
	output addr_t      o_awaddr,
	output logic [2:0] o_awsize,
	output logic       o_awvalid,
	input  logic       i_awready,
	output data_t      o_wdata,
	output strb_t      o_wstrb,
	output logic       o_wvalid,
	input  logic       i_wready,
	input  axi_resp_t  i_bresp,
	input  logic       i_bvalid,
	output logic       o_bready
);

	logic  if_bus_valid;
	addr_t if_bus_addr;
	logic  if_bus_ready;
	logic  if_bus_done;
	data_t if_bus_rdata;
	logic  if_bus_err;
	logic  ls_bus_valid;
	addr_t ls_bus_addr;
	logic  ls_bus_write;
	size_t ls_bus_size;
	data_t ls_bus_wdata;
	strb_t ls_bus_strb;
	logic  ls_bus_ready;
	logic  ls_bus_done;
	data_t ls_bus_rdata;
	logic  ls_bus_err;

	fetch_port i_fetch_port (
		.aclk        (aclk),
		.i_rst_n     (i_rst_n),
		.i_req_valid (i_if_req_valid),
		.o_req_ready (o_if_req_ready),
		.i_addr      (i_if_addr),
		.o_rsp_valid (o_if_rsp_valid),
		.o_rsp_data  (o_if_rsp_data),
		.o_rsp_err   (o_if_rsp_err),
		.i_rsp_ready (i_if_rsp_ready),
		.o_bus_valid (if_bus_valid),
		.o_bus_addr  (if_bus_addr),
		.i_bus_ready (if_bus_ready),
		.i_bus_done  (if_bus_done),
		.i_bus_rdata (if_bus_rdata),
		.i_bus_err   (if_bus_err)
	);

	ls_port i_ls_port (
		.aclk        (aclk),
		.i_rst_n     (i_rst_n),
		.i_req_valid (i_ls_req_valid),
		.o_req_ready (o_ls_req_ready),
		.i_addr      (i_ls_addr),
		.i_write     (i_ls_write),
		.i_size      (i_ls_size),
		.i_wdata     (i_ls_wdata),
		.o_rsp_valid (o_ls_rsp_valid),
		.o_rsp_data  (o_ls_rsp_data),
		.o_rsp_err   (o_ls_rsp_err),
		.i_rsp_ready (i_ls_rsp_ready),
		.o_bus_valid (ls_bus_valid),
		.o_bus_addr  (ls_bus_addr),
		.o_bus_write (ls_bus_write),
		.o_bus_size  (ls_bus_size),
		.o_bus_wdata (ls_bus_wdata),
		.o_bus_strb  (ls_bus_strb),
		.i_bus_ready (ls_bus_ready),
		.i_bus_done  (ls_bus_done),
		.i_bus_rdata (ls_bus_rdata),
		.i_bus_err   (ls_bus_err)
	);

	// clock, reset and AXI ports share names with the top
	axi_arbiter #(
		.LS_FIRST (LS_FIRST)
	) i_axi_arbiter (
		.i_if_bus_valid (if_bus_valid),
		.i_if_bus_addr  (if_bus_addr),
		.o_if_bus_ready (if_bus_ready),
		.o_if_bus_done  (if_bus_done),
		.o_if_bus_rdata (if_bus_rdata),
		.o_if_bus_err   (if_bus_err),
		.i_ls_bus_valid (ls_bus_valid),
		.i_ls_bus_addr  (ls_bus_addr),
		.i_ls_bus_write (ls_bus_write),
		.i_ls_bus_size  (ls_bus_size),
		.i_ls_bus_wdata (ls_bus_wdata),
		.i_ls_bus_strb  (ls_bus_strb),
		.o_ls_bus_ready (ls_bus_ready),
		.o_ls_bus_done  (ls_bus_done),
		.o_ls_bus_rdata (ls_bus_rdata),
		.o_ls_bus_err   (ls_bus_err),
		.*
	);

endmodule

/* design/axi_arbiter.sv */
`timescale 1ns/1ns

module axi_arbiter
	import cpu_mem_pkg::*;
#(
	parameter bit LS_FIRST = 1'b1   // winner of the first tie
) (
	input  logic       aclk,
	input  logic       i_rst_n,
	// fetch port
	input  logic       i_if_bus_valid,
	input  addr_t      i_if_bus_addr,
	output logic       o_if_bus_ready,
	output logic       o_if_bus_done,
	output data_t      o_if_bus_rdata,
	output logic       o_if_bus_err,
	// load/store port
	input  logic       i_ls_bus_valid,
	input  addr_t      i_ls_bus_addr,
	input  logic       i_ls_bus_write,
	input  size_t      i_ls_bus_size,
	input  data_t      i_ls_bus_wdata,
	input  strb_t      i_ls_bus_strb,
	output logic       o_ls_bus_ready,
	output logic       o_ls_bus_done,
	output data_t      o_ls_bus_rdata,
	output logic       o_ls_bus_err,
	// AXI master, single beat
	output addr_t      o_araddr,
	output logic [2:0] o_arsize,
	output logic       o_arvalid,
	input  logic       i_arready,
	input  data_t      i_rdata,
	input  axi_resp_t  i_rresp,
	input  logic       i_rvalid,
	output logic       o_rready,
	output addr_t      o_awaddr,
	output logic [2:0] o_awsize,
	output logic       o_awvalid,
	input  logic       i_awready,
	output data_t      o_wdata,
	output strb_t      o_wstrb,
	output logic       o_wvalid,
	input  logic       i_wready,
	input  axi_resp_t  i_bresp,
	input  logic       i_bvalid,
	output logic       o_bready
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_GRANT,
		ST_READ,
		ST_WRITE,
		ST_DONE
	} state_t;

	state_t state;
	logic   gnt_if;
	logic   gnt_ls;
	logic   prio_ls;   // load/store wins a tie
	logic   pick_ls;
	logic   arvalid_q;
	logic   awvalid_q;
	logic   wvalid_q;
	addr_t  addr_q;
	size_t  size_q;
	data_t  wdata_q;
	strb_t  strb_q;
	data_t  rdata_q;
	logic   err_q;
	logic   r_fire;
	logic   b_fire;

	assign pick_ls = i_ls_bus_valid && (prio_ls || !i_if_bus_valid);
	assign r_fire  = i_rvalid && o_rready;
	assign b_fire  = i_bvalid && o_bready;

	always_ff @(posedge aclk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state     <= ST_IDLE;
			gnt_if    <= 1'b0;
			gnt_ls    <= 1'b0;
			prio_ls   <= LS_FIRST;
			arvalid_q <= 1'b0;
			awvalid_q <= 1'b0;
			wvalid_q  <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (i_if_bus_valid || i_ls_bus_valid) begin
						state  <= ST_GRANT;
						gnt_ls <= pick_ls;
						gnt_if <= !pick_ls;
					end
				end
				ST_GRANT: begin
					if (gnt_ls && i_ls_bus_write) begin
						state     <= ST_WRITE;
						awvalid_q <= 1'b1;   // aw and w raised together
						wvalid_q  <= 1'b1;
					end else begin
						state     <= ST_READ;
						arvalid_q <= 1'b1;
					end
				end
				ST_READ: begin
					if (i_arready) arvalid_q <= 1'b0;
					if (r_fire) state <= ST_DONE;
				end
				ST_WRITE: begin
					if (i_awready) awvalid_q <= 1'b0;
					if (i_wready) wvalid_q <= 1'b0;
					if (b_fire) state <= ST_DONE;
				end
				default: begin
					state   <= ST_IDLE;
					prio_ls <= gnt_if;   // other port wins the next tie
					gnt_if  <= 1'b0;
					gnt_ls  <= 1'b0;
				end
			endcase
		end
	end

	// request fields are stable in the grant cycle
	always_ff @(posedge aclk) begin
		if (state == ST_GRANT) begin
			addr_q  <= gnt_ls ? i_ls_bus_addr : i_if_bus_addr;
			size_q  <= gnt_ls ? i_ls_bus_size : SIZE_WORD;
			wdata_q <= i_ls_bus_wdata;
			strb_q  <= i_ls_bus_strb;
		end
		if (r_fire) begin
			rdata_q <= i_rdata;
			err_q   <= (i_rresp != RESP_OKAY);
		end else if (b_fire) begin
			err_q <= (i_bresp != RESP_OKAY);
		end
	end

	assign o_if_bus_ready = (state == ST_GRANT) && gnt_if;
	assign o_ls_bus_ready = (state == ST_GRANT) && gnt_ls;
	assign o_if_bus_done  = (state == ST_DONE) && gnt_if;
	assign o_ls_bus_done  = (state == ST_DONE) && gnt_ls;
	assign o_if_bus_rdata = rdata_q;
	assign o_ls_bus_rdata = rdata_q;
	assign o_if_bus_err   = gnt_if && err_q;
	assign o_ls_bus_err   = gnt_ls && err_q;

	assign o_araddr  = addr_q;
	assign o_arsize  = {1'b0, size_q};
	assign o_arvalid = arvalid_q;
	assign o_rready  = (state == ST_READ);
	assign o_awaddr  = addr_q;
	assign o_awsize  = {1'b0, size_q};
	assign o_awvalid = awvalid_q;
	assign o_wdata   = wdata_q;
	assign o_wstrb   = strb_q;
	assign o_wvalid  = wvalid_q;
	assign o_bready  = (state == ST_WRITE) && !awvalid_q && !wvalid_q;   // b after aw and w

	a_one_grant: assert property (@(posedge aclk) disable iff (!i_rst_n)
		$onehot0({gnt_if, gnt_ls}) && ((state != ST_IDLE) == (gnt_if || gnt_ls)));
	a_no_rw_overlap: assert property (@(posedge aclk) disable iff (!i_rst_n)
		!(o_arvalid && o_awvalid));
	a_ar_hold: assert property (@(posedge aclk) disable iff (!i_rst_n)
		o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr));
	a_aw_hold: assert property (@(posedge aclk) disable iff (!i_rst_n)
		o_awvalid && !i_awready |=> o_awvalid && $stable(o_awaddr));
	a_w_hold: assert property (@(posedge aclk) disable iff (!i_rst_n)
		o_wvalid && !i_wready |=> o_wvalid && $stable(o_wdata) && $stable(o_wstrb));

endmodule

/* design/ls_port.sv */
`timescale 1ns/1ns

module ls_port
	import cpu_mem_pkg::*;
(
	input  logic  aclk,
	input  logic  i_rst_n,
	// load/store request and response
	input  logic  i_req_valid,
	output logic  o_req_ready,
	input  addr_t i_addr,
	input  logic  i_write,
	input  size_t i_size,
	input  data_t i_wdata,
	output logic  o_rsp_valid,
	output data_t o_rsp_data,
	output logic  o_rsp_err,
	input  logic  i_rsp_ready,
	// towards the arbiter
	output logic  o_bus_valid,
	output addr_t o_bus_addr,
	output logic  o_bus_write,
	output size_t o_bus_size,
	output data_t o_bus_wdata,
	output strb_t o_bus_strb,
	input  logic  i_bus_ready,
	input  logic  i_bus_done,
	input  data_t i_bus_rdata,
	input  logic  i_bus_err
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BUS,
		ST_RSP
	} state_t;

	state_t state;
	logic   bus_valid_q;
	addr_t  bus_addr_q;
	logic   bus_write_q;
	size_t  bus_size_q;
	data_t  bus_wdata_q;
	strb_t  bus_strb_q;
	data_t  rsp_data_q;
	logic   rsp_err_q;
	logic   req_fire;
	logic   misaligned;
	strb_t  lane_strb;
	data_t  lane_wdata;
	data_t  lane_shift;
	data_t  load_data;

	assign req_fire = i_req_valid && o_req_ready;

	// strobes, lane copies of the store data and the alignment rule
	always_comb begin
		case (i_size)
			SIZE_BYTE: begin
				misaligned = 1'b0;
				lane_strb  = strb_t'(1) << i_addr[1:0];
				lane_wdata = {STRB_W{i_wdata[7:0]}};
			end
			SIZE_HALF: begin
				misaligned = i_addr[0];
				lane_strb  = strb_t'(3) << i_addr[1:0];
				lane_wdata = {(STRB_W/2){i_wdata[15:0]}};
			end
			SIZE_WORD: begin
				misaligned = |i_addr[1:0];
				lane_strb  = '1;
				lane_wdata = i_wdata;
			end
			default: begin   // reserved size code
				misaligned = 1'b1;
				lane_strb  = '0;
				lane_wdata = i_wdata;
			end
		endcase
	end

	// addressed lanes down to bit 0, zero-extended
	assign lane_shift = i_bus_rdata >> {bus_addr_q[1:0], 3'b000};

	always_comb begin
		case (bus_size_q)
			SIZE_BYTE: load_data = {{(DATA_W-8){1'b0}}, lane_shift[7:0]};
			SIZE_HALF: load_data = {{(DATA_W-16){1'b0}}, lane_shift[15:0]};
			default:   load_data = lane_shift;
		endcase
	end

	always_ff @(posedge aclk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state       <= ST_IDLE;
			bus_valid_q <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (req_fire) begin
						state       <= misaligned ? ST_RSP : ST_BUS;
						bus_valid_q <= !misaligned;
					end
				end
				ST_BUS: begin
					if (i_bus_ready) begin
						bus_valid_q <= 1'b0;
					end
					if (i_bus_done) begin
						state <= ST_RSP;
					end
				end
				default: begin
					if (i_rsp_ready) begin
						state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (req_fire) begin
			bus_addr_q  <= virt_to_phys(i_addr);
			bus_write_q <= i_write;
			bus_size_q  <= i_size;
			bus_wdata_q <= lane_wdata;
			bus_strb_q  <= lane_strb;
			rsp_data_q  <= '0;
			rsp_err_q   <= misaligned;
		end else if (state == ST_BUS && i_bus_done) begin
			rsp_data_q <= bus_write_q ? '0 : load_data;   // stores return zero
			rsp_err_q  <= i_bus_err;
		end
	end

	assign o_req_ready = (state == ST_IDLE);
	assign o_rsp_valid = (state == ST_RSP);
	assign o_rsp_data  = rsp_data_q;
	assign o_rsp_err   = rsp_err_q;
	assign o_bus_valid = bus_valid_q;
	assign o_bus_addr  = bus_addr_q;
	assign o_bus_write = bus_write_q;
	assign o_bus_size  = bus_size_q;
	assign o_bus_wdata = bus_wdata_q;
	assign o_bus_strb  = bus_strb_q;

	// strobes cover exactly the access width, none below the start byte
	a_strb_in_range: assert property (@(posedge aclk) disable iff (!i_rst_n)
		o_bus_valid |-> ($countones(o_bus_strb) == (1 << o_bus_size))
			&& ((o_bus_strb & ((strb_t'(1) << o_bus_addr[1:0]) - strb_t'(1))) == '0));

endmodule

/* design/fetch_port.sv */
`timescale 1ns/1ns

module fetch_port
	import cpu_mem_pkg::*;
(
	input  logic  aclk,
	input  logic  i_rst_n,
	// fetch request and response
	input  logic  i_req_valid,
	output logic  o_req_ready,
	input  addr_t i_addr,
	output logic  o_rsp_valid,
	output data_t o_rsp_data,
	output logic  o_rsp_err,
	input  logic  i_rsp_ready,
	// towards the arbiter
	output logic  o_bus_valid,
	output addr_t o_bus_addr,
	input  logic  i_bus_ready,
	input  logic  i_bus_done,
	input  data_t i_bus_rdata,
	input  logic  i_bus_err
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BUS,
		ST_RSP
	} state_t;

	state_t state;
	logic   bus_valid_q;
	addr_t  bus_addr_q;
	data_t  rsp_data_q;
	logic   rsp_err_q;
	addr_t  phys_addr;
	logic   misaligned;
	logic   req_fire;

	assign phys_addr  = virt_to_phys(i_addr);
	assign misaligned = |i_addr[1:0];   // word fetches only
	assign req_fire   = i_req_valid && o_req_ready;

	always_ff @(posedge aclk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state       <= ST_IDLE;
			bus_valid_q <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (req_fire) begin
						state       <= misaligned ? ST_RSP : ST_BUS;
						bus_valid_q <= !misaligned;
					end
				end
				ST_BUS: begin
					if (i_bus_ready) begin
						bus_valid_q <= 1'b0;   // granted, now wait for done
					end
					if (i_bus_done) begin
						state <= ST_RSP;
					end
				end
				default: begin
					if (i_rsp_ready) begin
						state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (req_fire) begin
			bus_addr_q <= phys_addr;
			rsp_data_q <= '0;
			rsp_err_q  <= misaligned;   // address error, no bus cycle
		end else if (state == ST_BUS && i_bus_done) begin
			rsp_data_q <= i_bus_rdata;
			rsp_err_q  <= i_bus_err;
		end
	end

	assign o_req_ready = (state == ST_IDLE);
	assign o_rsp_valid = (state == ST_RSP);
	assign o_rsp_data  = rsp_data_q;
	assign o_rsp_err   = rsp_err_q;
	assign o_bus_valid = bus_valid_q;
	assign o_bus_addr  = bus_addr_q;

	// a held response must not start another bus cycle
	a_no_bus_during_rsp: assert property (@(posedge aclk) disable iff (!i_rst_n)
		$rose(o_bus_valid) |-> !$past(o_rsp_valid));

endmodule

/* design/cpu_mem_pkg.sv */
package cpu_mem_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [STRB_W-1:0] strb_t;

	// same code as AXI arsize/awsize for 1, 2 and 4 bytes
	typedef logic [1:0] size_t;
	localparam size_t SIZE_BYTE = 2'b00;
	localparam size_t SIZE_HALF = 2'b01;
	localparam size_t SIZE_WORD = 2'b10;

	typedef logic [1:0] axi_resp_t;
	localparam axi_resp_t RESP_OKAY   = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;   // error window in the memory model

	// top three address bits of the unmapped segments
	localparam logic [2:0] SEG_KSEG0 = 3'b100;   // cached in the full CPU
	localparam logic [2:0] SEG_KSEG1 = 3'b101;

	// kseg0 and kseg1 both fold onto the low 512 MB
	function automatic addr_t virt_to_phys(input addr_t vaddr);
		addr_t paddr;
		logic [2:0] seg;
		paddr = vaddr;
		seg = vaddr[ADDR_W-1 -: 3];
		if (seg == SEG_KSEG0 || seg == SEG_KSEG1) begin
			paddr[ADDR_W-1 -: 3] = 3'b000;
		end
		return paddr;   // user and kseg2/3 pass unchanged
	endfunction

endpackage
